//--- common/fp_format_pkg.sv
`default_nettype none

// single precision field layout shared by fp_mul and fp_add
package fp_format_pkg;

    localparam int FP_EXP_W = 8;    // biased exponent field
    localparam int FP_MAN_W = 23;   // stored fraction, hidden one not counted
    localparam int FP_BIAS  = 127;
    localparam int FP_W     = 1 + FP_EXP_W + FP_MAN_W;

    typedef logic [FP_W-1:0]     fp_word_t;   // raw ieee word
    typedef logic [FP_EXP_W-1:0] fp_exp_t;    // biased exponent
    typedef logic [FP_MAN_W:0]   fp_man_t;    // hidden one on top

    // exponent with headroom for carry out and for underflow below zero
    typedef logic signed [FP_EXP_W+1:0] fp_exp_ext_t;

    // field view of a word, same bit order as fp_word_t
    typedef struct packed {
        logic                sign;
        fp_exp_t             exp;
        logic [FP_MAN_W-1:0] frac;
    } fp_fields_t;

endpackage

`default_nettype wire

//--- common/pe_op_pkg.sv
`default_nettype none

// operation codes and the streamed beat format of the pe
package pe_op_pkg;

    import fp_format_pkg::*;

    // 3-bit op code, arrives together with the operands
    typedef enum logic [2:0] {
        OP_ADD  = 3'b000,   // inp1 + inp2
        OP_ACC  = 3'b001,   // streaming accumulate, not built, runs as nop
        OP_MUL  = 3'b010,   // inp1 * inp2
        OP_MACC = 3'b011,   // inp1 * inp2 + inp3
        OP_NOP  = 3'b100
    } pe_op_e;

    // one streamed value with its valid bit
    // valid sits above data, so {valid, data} packs as in the vector form
    typedef struct packed {
        logic     valid;
        fp_word_t data;
    } fp_beat_t;

endpackage

`default_nettype wire

//--- verilog/register_pipe.sv
`timescale 1ns/10ps
`default_nettype none

// plain delay line, DEPTH clocks from i_d to o_q
module register_pipe #(
    parameter int WIDTH = 33,
    parameter int DEPTH = 1     // 0 gives a straight connection
) (
    input  wire logic             clk,
    input  wire logic             i_rst_n,
    input  wire logic [WIDTH-1:0] i_d,
    output logic      [WIDTH-1:0] o_q
);

    generate
        if (DEPTH == 0) begin : g_bypass
            assign o_q = i_d;   // folded stage in the arithmetic units
        end else begin : g_chain
            logic [WIDTH-1:0] stage_q [DEPTH];

            always_ff @(posedge clk) begin
                if (!i_rst_n) begin
                    for (int i = 0; i < DEPTH; i++) begin
                        stage_q[i] <= '0;   // clears valid bits too
                    end
                end else begin
                    stage_q[0] <= i_d;
                    for (int i = 1; i < DEPTH; i++) begin
                        stage_q[i] <= stage_q[i-1];   // shift by one
                    end
                end
            end

            assign o_q = stage_q[DEPTH-1];
        end
    endgenerate

endmodule

`default_nettype wire

//--- fp_unit/fp_mul.sv
`timescale 1ns/10ps
`default_nettype none

// pipelined fp32 multiply, normal numbers and zero only, truncating
module fp_mul
    import fp_format_pkg::*;
    import pe_op_pkg::*;
#(
    parameter int STAGES = 8    // total latency, 2 or more
) (
    input  wire logic     clk,
    input  wire logic     i_rst_n,
    input  wire fp_beat_t i_a,
    input  wire fp_beat_t i_b,
    output fp_beat_t      o_res
);

    localparam int PROD_W = 2 * (FP_MAN_W + 1);   // full 24x24 product

    typedef struct packed {
        logic              valid;
        logic              sign;
        logic              zero;    // some input was zero or denormal
        fp_exp_ext_t       exp;     // rebiased exponent sum
        logic [PROD_W-1:0] prod;
    } mul_s1_t;

    fp_fields_t          a_f;
    fp_fields_t          b_f;
    fp_man_t             a_man;
    fp_man_t             b_man;
    mul_s1_t             s1;
    fp_exp_ext_t         norm_exp;
    logic [FP_MAN_W-1:0] norm_frac;
    fp_fields_t          res_f;
    fp_beat_t            s2;

    assign a_f   = i_a.data;
    assign b_f   = i_b.data;
    assign a_man = {1'b1, a_f.frac};   // hidden one back in
    assign b_man = {1'b1, b_f.frac};

    // stage 1 sign, exponent and raw product
    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            s1.valid <= 1'b0;
        end else begin
            s1.valid <= i_a.valid & i_b.valid;
        end
        s1.sign <= a_f.sign ^ b_f.sign;
        s1.zero <= (a_f.exp == '0) | (b_f.exp == '0);   // denormals flush
        s1.exp  <= fp_exp_ext_t'(a_f.exp) + fp_exp_ext_t'(b_f.exp) - fp_exp_ext_t'(FP_BIAS);
        s1.prod <= PROD_W'(a_man) * PROD_W'(b_man);
    end

    // product of two 1.x values lies in [1,4), so at most one bit of shift
    always_comb begin
        if (s1.prod[PROD_W-1]) begin
            norm_exp  = s1.exp + fp_exp_ext_t'(1);
            norm_frac = s1.prod[PROD_W-2 -: FP_MAN_W];
        end else begin
            norm_exp  = s1.exp;
            norm_frac = s1.prod[PROD_W-3 -: FP_MAN_W];
        end
        res_f.sign = s1.sign;
        res_f.exp  = norm_exp[FP_EXP_W-1:0];   // no overflow to inf
        res_f.frac = norm_frac;                // low bits dropped
        if (s1.zero || norm_exp <= 0) begin
            res_f = '0;   // zero operand or underflow
        end
    end

    // stage 2 packed result
    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            s2.valid <= 1'b0;
        end else begin
            s2.valid <= s1.valid;
        end
        s2.data <= res_f;
    end

    // remaining cycles up to STAGES
    register_pipe #(
        .WIDTH($bits(fp_beat_t)),
        .DEPTH(STAGES - 2)
    ) pad_pipe (
        .clk    (clk),
        .i_rst_n(i_rst_n),
        .i_d    (s2),
        .o_q    (o_res)
    );

endmodule

`default_nettype wire

//--- fp_unit/fp_add.sv
`timescale 1ns/10ps
`default_nettype none

// pipelined fp32 add, normal numbers and zero only, truncating
// order, align, add/sub, normalize+pack
module fp_add
    import fp_format_pkg::*;
    import pe_op_pkg::*;
#(
    parameter int STAGES = 8    // total latency, 2 or more
) (
    input  wire logic     clk,
    input  wire logic     i_rst_n,
    input  wire fp_beat_t i_a,
    input  wire fp_beat_t i_b,
    output fp_beat_t      o_res
);

    localparam int GRD_W = 3;                     // guard bits below the lsb
    localparam int EXT_W = FP_MAN_W + 1 + GRD_W;  // aligned mantissa width
    localparam int LZ_W  = $clog2(EXT_W + 1);
    // short pipes fold the early stages, pack stage always registered
    localparam int D1 = (STAGES >= 4) ? 1 : 0;
    localparam int D2 = (STAGES >= 3) ? 1 : 0;
    localparam int D4 = (STAGES >= 4) ? STAGES - 3 : 1;   // pack + padding

    typedef struct packed {
        logic    valid;
        logic    sign;       // sign of the larger magnitude
        logic    sub;        // signs differ
        fp_exp_t exp;
        fp_exp_t diff;
        fp_man_t man_big;
        fp_man_t man_small;
    } add_s1_t;

    typedef struct packed {
        logic             valid;
        logic             sign;
        logic             sub;
        fp_exp_t          exp;
        logic [EXT_W-1:0] man_big;
        logic [EXT_W-1:0] man_small;   // already shifted
    } add_s2_t;

    typedef struct packed {
        logic           valid;
        logic           sign;
        fp_exp_t        exp;
        logic [EXT_W:0] sum;   // one carry bit on top
    } add_s3_t;

    fp_fields_t      a_f;
    fp_fields_t      b_f;
    fp_fields_t      big_f;
    fp_fields_t      small_f;
    logic            swap;
    add_s1_t         s1_d;
    add_s1_t         s1_q;
    add_s2_t         s2_d;
    add_s2_t         s2_q;
    add_s3_t         s3_d;
    add_s3_t         s3_q;
    logic [LZ_W-1:0] lz;
    logic [EXT_W:0]  norm_sum;
    fp_exp_ext_t     res_exp;
    fp_fields_t      res_f;
    fp_beat_t        s4_d;

    assign a_f     = i_a.data;
    assign b_f     = i_b.data;
    assign swap    = {b_f.exp, b_f.frac} > {a_f.exp, a_f.frac};   // magnitude compare
    assign big_f   = swap ? b_f : a_f;
    assign small_f = swap ? a_f : b_f;

    // stage 1 order operands
    always_comb begin
        s1_d.valid     = i_a.valid & i_b.valid;
        s1_d.sign      = big_f.sign;
        s1_d.sub       = big_f.sign ^ small_f.sign;
        s1_d.exp       = big_f.exp;
        s1_d.diff      = big_f.exp - small_f.exp;   // never negative
        s1_d.man_big   = (big_f.exp == '0) ? '0 : {1'b1, big_f.frac};
        s1_d.man_small = (small_f.exp == '0) ? '0 : {1'b1, small_f.frac};
    end

    register_pipe #(.WIDTH($bits(add_s1_t)), .DEPTH(D1)) s1_pipe (
        .clk(clk), .i_rst_n(i_rst_n), .i_d(s1_d), .o_q(s1_q)
    );

    // stage 2 align the smaller one
    always_comb begin
        s2_d.valid     = s1_q.valid;
        s2_d.sign      = s1_q.sign;
        s2_d.sub       = s1_q.sub;
        s2_d.exp       = s1_q.exp;
        s2_d.man_big   = {s1_q.man_big, {GRD_W{1'b0}}};
        s2_d.man_small = {s1_q.man_small, {GRD_W{1'b0}}} >> s1_q.diff;   // big diff gives 0
    end

    register_pipe #(.WIDTH($bits(add_s2_t)), .DEPTH(D2)) s2_pipe (
        .clk(clk), .i_rst_n(i_rst_n), .i_d(s2_d), .o_q(s2_q)
    );

    // stage 3 magnitude add or subtract
    always_comb begin
        s3_d.valid = s2_q.valid;
        s3_d.sign  = s2_q.sign;
        s3_d.exp   = s2_q.exp;
        if (s2_q.sub) begin
            s3_d.sum = {1'b0, s2_q.man_big} - {1'b0, s2_q.man_small};   // big >= small
        end else begin
            s3_d.sum = {1'b0, s2_q.man_big} + {1'b0, s2_q.man_small};
        end
    end

    register_pipe #(.WIDTH($bits(add_s3_t)), .DEPTH(1)) s3_pipe (
        .clk(clk), .i_rst_n(i_rst_n), .i_d(s3_d), .o_q(s3_q)
    );

    // stage 4 leading one, normalize, pack
    always_comb begin
        lz = '0;
        for (int i = 0; i <= EXT_W; i++) begin
            if (s3_q.sum[i]) begin
                lz = LZ_W'(EXT_W - i);   // highest set bit wins
            end
        end
        norm_sum = s3_q.sum << lz;
        // carry bit position stands for exp + 1
        res_exp    = fp_exp_ext_t'(s3_q.exp) + fp_exp_ext_t'(1) - fp_exp_ext_t'(lz);
        res_f.sign = s3_q.sign;
        res_f.exp  = res_exp[FP_EXP_W-1:0];
        res_f.frac = norm_sum[EXT_W-1 -: FP_MAN_W];   // guard bits dropped
        if (s3_q.sum == '0 || res_exp <= 0) begin
            res_f = '0;   // exact zero or underflow
        end
        s4_d.valid = s3_q.valid;
        s4_d.data  = res_f;
    end

    register_pipe #(.WIDTH($bits(fp_beat_t)), .DEPTH(D4)) s4_pipe (
        .clk(clk), .i_rst_n(i_rst_n), .i_d(s4_d), .o_q(o_res)
    );

endmodule

`default_nettype wire

//--- verilog/pe_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

// op decode for the pe
// carries the op alongside the data and drives every select
module pe_ctrl
    import pe_op_pkg::*;
#(
    parameter int LATENCY = 16
) (
    input  wire logic   clk,
    input  wire logic   i_rst_n,
    input  wire pe_op_e i_op,
    input  wire logic   i_valid1,        // inp1 valid, LATENCY/2 after entry
    input  wire logic   i_valid2,        // inp2 valid, same point
    output logic        o_mul_en,        // at entry
    output logic        o_add_macc,      // product + inp3 into the adder
    output logic        o_add_en,        // adder operands valid
    output logic        o_out_sel_mul,   // out1 from the delayed product
    output logic        o_out_en         // out1 may be valid
);

    localparam int OP_W = $bits(pe_op_e);

    logic [OP_W-1:0] op_d;    // op at the adder input
    logic [OP_W-1:0] op_dd;   // op at the output

    // only mul and macc use the multiplier
    assign o_mul_en = (i_op == OP_MUL) || (i_op == OP_MACC);

    register_pipe #(
        .WIDTH(OP_W),
        .DEPTH(LATENCY / 2)
    ) op_pipe_d (
        .clk    (clk),
        .i_rst_n(i_rst_n),
        .i_d    (i_op),
        .o_q    (op_d)
    );

    assign o_add_macc = (op_d == OP_MACC);
    // both streamed operands must have been valid
    assign o_add_en   = i_valid1 & i_valid2 & ((op_d == OP_ADD) || (op_d == OP_MACC));

    register_pipe #(
        .WIDTH(OP_W),
        .DEPTH(LATENCY / 2)
    ) op_pipe_dd (
        .clk    (clk),
        .i_rst_n(i_rst_n),
        .i_d    (op_d),
        .o_q    (op_dd)
    );

    assign o_out_sel_mul = (op_dd == OP_MUL);
    // acc, nop and unknown codes never give a result
    assign o_out_en      = (op_dd == OP_ADD) || (op_dd == OP_MUL) || (op_dd == OP_MACC);

endmodule

`default_nettype wire

//--- verilog/pe_typec.sv
`timescale 1ns/10ps
`default_nettype none

// fp processing element, type c
// half the latency in the multiplier and half in the adder
module pe_typec
    import fp_format_pkg::*;
    import pe_op_pkg::*;
#(
    parameter int LATENCY = 16   // even, 4 or more
) (
    input  wire logic     clk,
    input  wire logic     i_rst_n,
    input  wire fp_beat_t i_inp1,
    input  wire fp_beat_t i_inp2,
    input  wire fp_word_t i_inp3,   // side operand, always valid
    input  wire pe_op_e   i_op,
    output fp_beat_t      o_out1,   // arithmetic result
    output fp_beat_t      o_out2    // inp1 passed on
);

    localparam int HALF = LATENCY / 2;

    fp_beat_t inp1_d;    // operands at the adder input
    fp_beat_t inp2_d;
    fp_word_t inp3_d;
    fp_beat_t mul_a;
    fp_beat_t mul_b;
    fp_beat_t mul_res;
    fp_beat_t mul_d;     // product lined up with the adder output
    fp_beat_t add_a;
    fp_beat_t add_b;
    fp_beat_t add_res;
    logic     mul_en;
    logic     add_macc;
    logic     add_en;
    logic     out_sel_mul;
    logic     out_en;

    pe_ctrl #(.LATENCY(LATENCY)) pe_ctrl_i (
        .clk          (clk),
        .i_rst_n      (i_rst_n),
        .i_op         (i_op),
        .i_valid1     (inp1_d.valid),
        .i_valid2     (inp2_d.valid),
        .o_mul_en     (mul_en),
        .o_add_macc   (add_macc),
        .o_add_en     (add_en),
        .o_out_sel_mul(out_sel_mul),
        .o_out_en     (out_en)
    );

    register_pipe #(.WIDTH($bits(fp_beat_t)), .DEPTH(LATENCY)) out2_pipe (
        .clk(clk), .i_rst_n(i_rst_n), .i_d(i_inp1), .o_q(o_out2)
    );
    register_pipe #(.WIDTH($bits(fp_beat_t)), .DEPTH(HALF)) inp1_pipe (
        .clk(clk), .i_rst_n(i_rst_n), .i_d(i_inp1), .o_q(inp1_d)
    );
    register_pipe #(.WIDTH($bits(fp_beat_t)), .DEPTH(HALF)) inp2_pipe (
        .clk(clk), .i_rst_n(i_rst_n), .i_d(i_inp2), .o_q(inp2_d)
    );
    register_pipe #(.WIDTH($bits(fp_word_t)), .DEPTH(HALF)) inp3_pipe (
        .clk(clk), .i_rst_n(i_rst_n), .i_d(i_inp3), .o_q(inp3_d)
    );

    // multiplier sees valid operands for mul and macc only
    assign mul_a = '{valid: i_inp1.valid & mul_en, data: i_inp1.data};
    assign mul_b = '{valid: i_inp2.valid & mul_en, data: i_inp2.data};

    fp_mul #(.STAGES(HALF)) fp_mul_i (
        .clk(clk), .i_rst_n(i_rst_n), .i_a(mul_a), .i_b(mul_b), .o_res(mul_res)
    );

    register_pipe #(.WIDTH($bits(fp_beat_t)), .DEPTH(HALF)) mul_pipe (
        .clk(clk), .i_rst_n(i_rst_n), .i_d(mul_res), .o_q(mul_d)
    );

    // add takes inp1 + inp2, macc takes product + inp3
    assign add_a = '{valid: add_en, data: add_macc ? mul_res.data : inp1_d.data};
    assign add_b = '{valid: add_en, data: add_macc ? inp3_d : inp2_d.data};

    fp_add #(.STAGES(HALF)) fp_add_i (
        .clk(clk), .i_rst_n(i_rst_n), .i_a(add_a), .i_b(add_b), .o_res(add_res)
    );

    always_comb begin
        if (out_sel_mul) begin
            o_out1.data  = mul_d.data;
            o_out1.valid = out_en & mul_d.valid;
        end else begin
            o_out1.data  = add_res.data;
            o_out1.valid = out_en & add_res.valid;   // low for nop codes
        end
    end

endmodule

`default_nettype wire

//--- bench/tb_pe_typec.sv
`timescale 1ns/10ps
`default_nettype none

// self-checking bench for pe_typec
// every beat is queued with its expected outputs, checked LATENCY edges later
module tb_pe_typec
    import fp_format_pkg::*;
    import pe_op_pkg::*;
();

    localparam int LATENCY    = 16;
    localparam int CLK_PERIOD = 40;
    localparam int RST_CYCLES = 4;
    localparam int SEED       = 4;
    localparam int N_RANDOM   = 200;
    localparam int N_DIRECTED = 40;   // directed beats, rounded up
    localparam int WATCHDOG_NS =
        (RST_CYCLES + N_DIRECTED + N_RANDOM + LATENCY + 20) * CLK_PERIOD;

    typedef struct packed {
        pe_op_e   op;     // kept for the error text
        fp_beat_t out1;
        fp_beat_t out2;
    } expect_t;

    logic     clk;
    logic     i_rst_n;
    fp_beat_t i_inp1;
    fp_beat_t i_inp2;
    fp_word_t i_inp3;
    pe_op_e   i_op;
    fp_beat_t o_out1;
    fp_beat_t o_out2;

    expect_t exp_q[$];    // one entry per sampled beat
    int      edge_cnt;    // rising edges since reset release
    int      n_checks;
    int      n_errors;

    pe_typec #(.LATENCY(LATENCY)) pe_typec_i (
        .clk    (clk),
        .i_rst_n(i_rst_n),
        .i_inp1 (i_inp1),
        .i_inp2 (i_inp2),
        .i_inp3 (i_inp3),
        .i_op   (i_op),
        .o_out1 (o_out1),
        .o_out2 (o_out2)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // exact encoding of a real, fine for the halves used here
    function automatic fp_word_t to_fp32(input real r);
        real         m;
        int          e;
        logic        s;
        logic [22:0] f;
        if (r == 0.0) begin
            return '0;   // always the positive zero word
        end
        s = (r < 0.0);
        m = s ? -r : r;
        e = 0;
        while (m >= 2.0) begin
            m = m / 2.0;
            e++;
        end
        while (m < 1.0) begin
            m = m * 2.0;
            e--;
        end
        f = 23'(longint'((m - 1.0) * 8388608.0));   // 2**23
        return {s, 8'(e + FP_BIAS), f};
    endfunction

    // small integers and halves in -64..64
    function automatic real rand_half();
        int k;
        k = int'($urandom_range(256)) - 128;
        return k / 2.0;
    endfunction

    // drive one beat at the falling edge and queue what must come out
    task automatic drive_beat(input pe_op_e op, input real a, input real b, input real c,
                              input logic v1, input logic v2);
        expect_t want;
        real     r;
        r = 0.0;
        if (op == OP_ADD) begin
            r = a + b;
        end else if (op == OP_MUL) begin
            r = a * b;
        end else if (op == OP_MACC) begin
            r = a * b + c;
        end
        want.op         = op;
        want.out2       = '{valid: v1, data: to_fp32(a)};   // inp1 passes through
        want.out1.valid = v1 && v2 && (op == OP_ADD || op == OP_MUL || op == OP_MACC);
        want.out1.data  = want.out1.valid ? to_fp32(r) : '0;
        i_inp1 = '{valid: v1, data: to_fp32(a)};
        i_inp2 = '{valid: v2, data: to_fp32(b)};
        i_inp3 = to_fp32(c);
        i_op   = op;
        exp_q.push_back(want);
        @(negedge clk);
    endtask

    // idle inputs with nothing queued, used for the drain
    task automatic release_inputs();
        i_inp1 = '0;
        i_inp2 = '0;
        i_inp3 = '0;
        i_op   = OP_NOP;
    endtask

    // sampled before the edge updates, so outputs are stable here
    always @(posedge clk) begin : check_outputs
        expect_t want;
        int      idx;
        if (i_rst_n) begin
            idx = edge_cnt - LATENCY;
            if (idx < 0 || exp_q.size() == 0) begin
                n_checks++;   // nothing due, both valids must be low
                assert (o_out1.valid === 1'b0 && o_out2.valid === 1'b0) else begin
                    n_errors++;
                    $display("mismatch %0t ns: valid set with no result due, out1 %b out2 %b",
                             $time, o_out1.valid, o_out2.valid);
                end
            end else begin
                want = exp_q.pop_front();
                n_checks++;
                if (want.out1.valid) begin
                    assert (o_out1 === want.out1) else begin
                        n_errors++;
                        $display("mismatch %0t ns: out1 %h, expected %h, op %s",
                                 $time, o_out1, want.out1, want.op.name());
                    end
                end else begin
                    assert (o_out1.valid === 1'b0) else begin
                        n_errors++;
                        $display("mismatch %0t ns: out1 valid set, op %s should give none",
                                 $time, want.op.name());
                    end
                end
                n_checks++;
                assert (o_out2 === want.out2) else begin
                    n_errors++;
                    $display("mismatch %0t ns: out2 %h, expected %h",
                             $time, o_out2, want.out2);
                end
            end
            edge_cnt++;
        end
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("timeout: run did not finish within %0d ns, %0d results outstanding",
                 WATCHDOG_NS, exp_q.size());
        $display("CHECKS FAILED");
        $finish;
    end

    initial begin : stimulus
        pe_op_e op;
        void'($urandom(SEED));
        edge_cnt = 0;
        n_checks = 0;
        n_errors = 0;
        i_rst_n  = 1'b0;
        release_inputs();
        repeat (RST_CYCLES) @(posedge clk);
        @(negedge clk);
        i_rst_n = 1'b1;

        // add, valid straight after reset
        drive_beat(OP_ADD, 1.5, 2.0, 9.0, 1'b1, 1'b1);
        drive_beat(OP_ADD, 3.5, -3.5, 9.0, 1'b1, 1'b1);    // exact zero
        drive_beat(OP_ADD, 64.0, -0.5, 9.0, 1'b1, 1'b1);   // exponents far apart
        drive_beat(OP_ADD, -5.0, 2.5, 9.0, 1'b1, 1'b1);
        drive_beat(OP_ADD, 0.5, 48.0, 9.0, 1'b1, 1'b1);
        drive_beat(OP_ADD, 0.0, 7.0, 9.0, 1'b1, 1'b1);
        drive_beat(OP_ADD, -12.0, -20.5, 9.0, 1'b1, 1'b1);
        // multiply
        drive_beat(OP_MUL, -3.0, 4.5, 9.0, 1'b1, 1'b1);
        drive_beat(OP_MUL, -2.0, -2.5, 9.0, 1'b1, 1'b1);
        drive_beat(OP_MUL, 0.0, 17.0, 9.0, 1'b1, 1'b1);    // zero word out
        drive_beat(OP_MUL, 64.0, 64.0, 9.0, 1'b1, 1'b1);
        drive_beat(OP_MUL, -0.5, 0.0, 9.0, 1'b1, 1'b1);    // sign dropped on zero
        drive_beat(OP_MUL, 7.5, -0.5, 9.0, 1'b1, 1'b1);
        // multiply-accumulate
        drive_beat(OP_MACC, 2.0, 3.0, 1.0, 1'b1, 1'b1);
        drive_beat(OP_MACC, -4.0, 4.0, 16.0, 1'b1, 1'b1);  // cancels to zero
        drive_beat(OP_MACC, 0.5, 0.5, -64.0, 1'b1, 1'b1);
        drive_beat(OP_MACC, -8.0, -8.0, -0.5, 1'b1, 1'b1);
        drive_beat(OP_MACC, 0.0, 5.0, 3.5, 1'b1, 1'b1);
        // codes without a result, inp1 still passed on
        drive_beat(OP_ACC, 6.0, 2.0, 1.0, 1'b1, 1'b1);
        drive_beat(OP_NOP, 6.5, 2.0, 1.0, 1'b1, 1'b1);
        drive_beat(pe_op_e'(3'b101), -7.0, 2.0, 1.0, 1'b1, 1'b1);
        drive_beat(pe_op_e'(3'b110), 8.5, 2.0, 1.0, 1'b1, 1'b1);
        drive_beat(pe_op_e'(3'b111), -9.0, 2.0, 1.0, 1'b1, 1'b1);
        drive_beat(OP_NOP, 10.0, 2.0, 1.0, 1'b0, 1'b1);
        // one operand valid only
        drive_beat(OP_ADD, 1.0, 2.0, 3.0, 1'b1, 1'b0);
        drive_beat(OP_ADD, 1.0, 2.0, 3.0, 1'b0, 1'b1);
        drive_beat(OP_MUL, 4.0, 2.0, 3.0, 1'b0, 1'b1);
        drive_beat(OP_MACC, 4.0, 2.0, 3.0, 1'b1, 1'b0);
        drive_beat(OP_MUL, 4.0, 2.0, 3.0, 1'b0, 1'b0);
        // short gap
        repeat (3) drive_beat(OP_NOP, 0.0, 0.0, 0.0, 1'b0, 1'b0);

        // back to back mix, one op per cycle
        for (int n = 0; n < N_RANDOM; n++) begin
            case ($urandom_range(2))
                0: op = OP_ADD;
                1: op = OP_MUL;
                default: op = OP_MACC;
            endcase
            drive_beat(op, rand_half(), rand_half(), rand_half(), 1'b1, 1'b1);
        end

        release_inputs();
        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
        repeat (2) @(negedge clk);   // a few empty checks after the last result
        $display("checks %0d, errors %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- src.f
common/fp_format_pkg.sv
common/pe_op_pkg.sv
verilog/register_pipe.sv
fp_unit/fp_mul.sv
fp_unit/fp_add.sv
verilog/pe_ctrl.sv
verilog/pe_typec.sv
bench/tb_pe_typec.sv

//--- run_sim.sh
#!/bin/sh
# build and run the pe testbench with verilator
cd "$(dirname "$0")" || exit 1

TOP=tb_pe_typec
OBJ=obj_dir
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/10ps \
    --top-module "$TOP" -f src.f -Mdir "$OBJ" -o "V$TOP"
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$OBJ/V$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

# the log decides pass or fail
if grep -q "CHECKS FAILED" "$LOG"; then
    echo "failure reported in $LOG"
    exit 1
fi

echo "no failure reported in $LOG"
exit 0
